// File: source/uart_config.svh
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// clock cycles per serial bit
// small value keeps simulated frames short
`define UART_CLKS_PER_BIT 8

// entries in each byte FIFO
`define UART_FIFO_DEPTH 16

`endif

// File: source/uart_pkg.sv
package uart_pkg;

    // width of one processor load or store
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } access_size_t;

    // position within an 8N1 frame, shared by receiver and transmitter
    typedef enum logic [1:0] {
        SER_IDLE  = 2'b00,
        SER_START = 2'b01,
        SER_DATA  = 2'b10,
        SER_STOP  = 2'b11
    } serial_state_t;

endpackage

// File: source/byte_fifo.sv
`timescale 1ns/1ps
`include "uart_config.svh"

module byte_fifo #(
    parameter int DEPTH        = `UART_FIFO_DEPTH,
    parameter bit DROP_ON_FULL = 1'b0
) (
    input  logic       clk,
    input  logic       i_rst,
    input  logic       i_push_valid,
    output logic       o_push_ready,
    input  logic [7:0] i_push_data,
    output logic       o_pop_valid,
    input  logic       i_pop_ready,
    output logic [7:0] o_pop_data,
    output logic       o_overrun
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [7:0]       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full        = count == CNT_W'(DEPTH);
    assign o_pop_valid = count != '0;
    assign o_pop_data  = mem[rd_ptr];
    assign do_pop      = o_pop_valid && i_pop_ready;

    // a full queue still takes a byte when one leaves in the same cycle
    assign o_push_ready = DROP_ON_FULL ? 1'b1 : (!full || i_pop_ready);
    assign do_push      = i_push_valid && (!full || do_pop);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // sticky until reset
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_overrun <= 1'b0;
        end else if (DROP_ON_FULL && i_push_valid && !do_push) begin
            o_overrun <= 1'b1;
        end
    end

    if (!DROP_ON_FULL) begin : g_backpressure_chk
        // a full queue with no pop takes no push
        a_no_push_full: assert property (@(posedge clk) disable iff (i_rst)
            (full && !do_pop) |=> full);
    end

endmodule

// File: source/uart_rx.sv
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_rx
    import uart_pkg::*;
#(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic       clk,
    input  logic       i_rst,
    input  logic       i_rxd,
    output logic       o_valid,
    output logic [7:0] o_data
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int HALF  = (CLKS_PER_BIT > 1) ? CLKS_PER_BIT / 2 : 1;

    serial_state_t    state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_q;
    logic             rxd_meta;
    logic             rxd_sync;
    logic             rxd_prev;
    logic             start_edge;
    logic             mid_start;
    logic             bit_end;

    assign start_edge = rxd_prev && !rxd_sync;
    assign mid_start  = clk_cnt == CNT_W'(HALF - 1);
    assign bit_end    = clk_cnt == CNT_W'(CLKS_PER_BIT - 1);
    assign o_data     = shift_q;

    // line idles high, so the synchronizer comes out of reset high
    always_ff @(posedge clk) begin
        if (i_rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= i_rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state   <= SER_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            case (state)
                SER_IDLE: begin
                    clk_cnt <= '0;
                    if (start_edge) begin
                        state <= SER_START;
                    end
                end
                SER_START: begin
                    // glitch shorter than half a bit goes back to idle
                    if (mid_start) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rxd_sync ? SER_IDLE : SER_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                SER_DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= SER_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                SER_STOP: begin
                    // low stop bit is a framing error, byte dropped
                    if (bit_end) begin
                        clk_cnt <= '0;
                        o_valid <= rxd_sync;
                        state   <= SER_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= SER_IDLE;
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (state == SER_DATA && bit_end) begin
            shift_q <= {rxd_sync, shift_q[7:1]};
        end
    end

endmodule

// File: source/uart_tx.sv
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_tx
    import uart_pkg::*;
#(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic       clk,
    input  logic       i_rst,
    input  logic       i_valid,
    output logic       o_ready,
    input  logic [7:0] i_data,
    output logic       o_txd
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    serial_state_t    state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_q;
    logic             bit_end;

    assign o_ready = state == SER_IDLE;
    assign bit_end = clk_cnt == CNT_W'(CLKS_PER_BIT - 1);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state   <= SER_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            o_txd   <= 1'b1;
        end else begin
            clk_cnt <= (state == SER_IDLE || bit_end) ? '0 : clk_cnt + 1'b1;
            case (state)
                SER_IDLE: begin
                    if (i_valid) begin
                        state <= SER_START;
                        o_txd <= 1'b0;
                    end
                end
                SER_START: begin
                    if (bit_end) begin
                        state   <= SER_DATA;
                        bit_idx <= '0;
                        o_txd   <= shift_q[0];
                    end
                end
                SER_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= SER_STOP;
                            o_txd <= 1'b1;
                        end else begin
                            // next bit, ahead of the shift below
                            o_txd <= shift_q[1];
                        end
                    end
                end
                SER_STOP: begin
                    if (bit_end) begin
                        state <= SER_IDLE;
                    end
                end
                default: state <= SER_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_ready && i_valid) begin
            shift_q <= i_data;
        end else if (state == SER_DATA && bit_end) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    a_idle_high: assert property (@(posedge clk) disable iff (i_rst)
        (state == SER_IDLE) |-> o_txd);

endmodule

// File: source/uart_access.sv
`timescale 1ns/1ps

module uart_access
    import uart_pkg::*;
(
    input  logic         clk,
    input  logic         i_rst,
    input  logic         i_req_valid,
    output logic         o_req_ready,
    input  access_size_t i_size,
    input  logic         i_write,
    input  logic [31:0]  i_wdata,
    output logic         o_done,
    output logic [31:0]  o_rdata,
    output logic         o_tx_valid,
    output logic [7:0]   o_tx_data,
    input  logic         i_tx_ready,
    input  logic         i_rx_valid,
    input  logic [7:0]   i_rx_data,
    output logic         o_rx_ready
);

    logic [2:0]   byte_cnt;
    logic         busy;
    logic         write_q;
    access_size_t size_q;
    logic [31:0]  shift_q;
    logic [31:0]  rdata_q;
    logic [31:0]  read_word;
    logic [31:0]  read_ext;
    logic         accept;
    logic         byte_xfer;

    function automatic logic [2:0] size_bytes(input access_size_t size);
        case (size)
            SIZE_BYTE: return 3'd1;
            SIZE_HALF: return 3'd2;
            default:   return 3'd4;
        endcase
    endfunction

    // top byte goes out first
    function automatic logic [31:0] align_left(input access_size_t size,
                                               input logic [31:0] data);
        case (size)
            SIZE_BYTE: return {data[7:0], 24'h000000};
            SIZE_HALF: return {data[15:0], 16'h0000};
            default:   return data;
        endcase
    endfunction

    assign busy        = byte_cnt != 3'd0;
    assign o_req_ready = !busy;
    assign accept      = i_req_valid && o_req_ready;

    assign o_tx_valid = busy && write_q;
    assign o_tx_data  = shift_q[31:24];
    assign o_rx_ready = busy && !write_q;

    assign byte_xfer = (o_tx_valid && i_tx_ready) || (o_rx_ready && i_rx_valid);
    assign o_done    = byte_xfer && (byte_cnt == 3'd1);

    // received byte lands at the bottom, earlier bytes move up
    assign read_word = {shift_q[23:0], i_rx_data};

    always_comb begin
        case (size_q)
            SIZE_BYTE: read_ext = {{24{read_word[7]}}, read_word[7:0]};
            SIZE_HALF: read_ext = {{16{read_word[15]}}, read_word[15:0]};
            default:   read_ext = read_word;
        endcase
    end

    // read result shows in the done cycle, then held
    assign o_rdata = (o_done && !write_q) ? read_ext : rdata_q;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            byte_cnt <= 3'd0;
        end else if (accept) begin
            byte_cnt <= size_bytes(i_size);
        end else if (byte_xfer) begin
            byte_cnt <= byte_cnt - 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            write_q <= i_write;
            size_q  <= i_size;
            shift_q <= align_left(i_size, i_wdata);
        end else if (byte_xfer) begin
            if (write_q) begin
                shift_q <= {shift_q[23:0], 8'h00};
            end else begin
                shift_q <= read_word;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (o_done && !write_q) begin
            rdata_q <= read_ext;
        end
    end

    // idle with nothing accepted gives no done next cycle
    a_done_busy: assert property (@(posedge clk) disable iff (i_rst)
        (o_req_ready && !accept) |=> !o_done);

    // finishing an access frees the request side on the next cycle
    a_done_idle: assert property (@(posedge clk) disable iff (i_rst)
        o_done |=> o_req_ready);

endmodule

// File: source/uart_manage.sv
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_manage
    import uart_pkg::*;
#(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT,
    parameter int FIFO_DEPTH   = `UART_FIFO_DEPTH
) (
    input  logic         clk,
    input  logic         i_rst,
    input  logic         i_req_valid,
    output logic         o_req_ready,
    input  access_size_t i_size,
    input  logic         i_write,
    input  logic [31:0]  i_wdata,
    output logic         o_done,
    output logic [31:0]  o_rdata,
    input  logic         i_rxd,
    output logic         o_txd,
    output logic         o_overrun
);

    logic       rx_byte_valid;
    logic [7:0] rx_byte_data;
    logic       rxq_valid;
    logic       rxq_ready;
    logic [7:0] rxq_data;
    logic       tx_push_valid;
    logic       tx_push_ready;
    logic [7:0] tx_push_data;
    logic       txq_valid;
    logic       txq_ready;
    logic [7:0] txq_data;

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_rx (
        .clk    (clk),
        .i_rst  (i_rst),
        .i_rxd  (i_rxd),
        .o_valid(rx_byte_valid),
        .o_data (rx_byte_data)
    );

    // receiver cannot stall, so this queue drops on full
    byte_fifo #(
        .DEPTH       (FIFO_DEPTH),
        .DROP_ON_FULL(1'b1)
    ) u_rx_fifo (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_push_valid(rx_byte_valid),
        .o_push_ready(),
        .i_push_data (rx_byte_data),
        .o_pop_valid (rxq_valid),
        .i_pop_ready (rxq_ready),
        .o_pop_data  (rxq_data),
        .o_overrun   (o_overrun)
    );

    uart_access u_access (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_req_valid(i_req_valid),
        .o_req_ready(o_req_ready),
        .i_size     (i_size),
        .i_write    (i_write),
        .i_wdata    (i_wdata),
        .o_done     (o_done),
        .o_rdata    (o_rdata),
        .o_tx_valid (tx_push_valid),
        .o_tx_data  (tx_push_data),
        .i_tx_ready (tx_push_ready),
        .i_rx_valid (rxq_valid),
        .i_rx_data  (rxq_data),
        .o_rx_ready (rxq_ready)
    );

    byte_fifo #(
        .DEPTH       (FIFO_DEPTH),
        .DROP_ON_FULL(1'b0)
    ) u_tx_fifo (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_push_valid(tx_push_valid),
        .o_push_ready(tx_push_ready),
        .i_push_data (tx_push_data),
        .o_pop_valid (txq_valid),
        .i_pop_ready (txq_ready),
        .o_pop_data  (txq_data),
        .o_overrun   ()
    );

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_tx (
        .clk    (clk),
        .i_rst  (i_rst),
        .i_valid(txq_valid),
        .o_ready(txq_ready),
        .i_data (txq_data),
        .o_txd  (o_txd)
    );

endmodule

// File: verification/tb_uart_manage.sv
`timescale 1ns/1ps
`include "uart_config.svh"

module tb_uart_manage
    import uart_pkg::*;
();

    localparam int WAIT_LIMIT  = 4000;
    localparam int IDLE_CYCLES = 12 * `UART_CLKS_PER_BIT;

    logic         clk = 1'b0;
    logic         i_rst;
    logic         i_req_valid;
    logic         o_req_ready;
    access_size_t i_size;
    logic         i_write;
    logic [31:0]  i_wdata;
    logic         o_done;
    logic [31:0]  o_rdata;
    logic         serial_line;
    logic         o_overrun;

    logic [31:0]  lfsr_q = 32'hb807;
    logic [7:0]   exp_bytes[$];
    logic [31:0]  exp_rdata;
    logic         read_active;
    logic         pending;
    logic         ovr_check;
    logic         ovr_expect;
    int           done_cnt;
    int           done_base;
    int           errors   = 0;
    int           timeouts = 0;
    int           writes   = 0;
    int           reads    = 0;

    always #4 clk = ~clk;

    // txd looped straight back into rxd
    uart_manage u_uart_manage (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_req_valid(i_req_valid),
        .o_req_ready(o_req_ready),
        .i_size     (i_size),
        .i_write    (i_write),
        .i_wdata    (i_wdata),
        .o_done     (o_done),
        .o_rdata    (o_rdata),
        .i_rxd      (serial_line),
        .o_txd      (serial_line),
        .o_overrun  (o_overrun)
    );

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            w = {w[30:0], lfsr_q[0]};
        end
        return w;
    endfunction

    // an access is pending from acceptance until its done pulse
    always @(posedge clk) begin
        if (i_rst) begin
            pending  <= 1'b0;
            done_cnt <= 0;
        end else begin
            if (i_req_valid && o_req_ready) begin
                pending <= 1'b1;
            end else if (o_done) begin
                pending <= 1'b0;
            end
            if (o_done) begin
                done_cnt <= done_cnt + 1;
            end
        end
    end

    a_reset_state: assert property (@(posedge clk)
        i_rst |=> (serial_line && o_req_ready && !o_done && !o_overrun))
        else begin
            errors++;
            $display("FAIL %0t: outputs not at their reset values", $time);
        end

    a_rdata: assert property (@(posedge clk) disable iff (i_rst)
        (o_done && read_active) |-> (o_rdata == exp_rdata))
        else begin
            errors++;
            $display("FAIL %0t: read data %h, expected %h", $time,
                     $sampled(o_rdata), $sampled(exp_rdata));
        end

    a_ready_pending: assert property (@(posedge clk) disable iff (i_rst)
        pending |-> !o_req_ready)
        else begin
            errors++;
            $display("FAIL %0t: request ready while an access is pending", $time);
        end

    a_overrun: assert property (@(posedge clk) disable iff (i_rst)
        ovr_check |-> (o_overrun == ovr_expect))
        else begin
            errors++;
            $display("FAIL %0t: overrun is %b, expected %b", $time,
                     $sampled(o_overrun), $sampled(ovr_expect));
        end

    // drive one request, wait for acceptance and then for done
    task automatic run_access(input access_size_t size, input logic write,
                              input logic [31:0] wdata);
        int n;
        bit accepted;
        bit finished;
        accepted    = 1'b0;
        finished    = 1'b0;
        n           = 0;
        i_req_valid = 1'b1;
        i_size      = size;
        i_write     = write;
        i_wdata     = wdata;
        while (!accepted && n < WAIT_LIMIT) begin
            @(negedge clk);
            accepted = o_req_ready;
            @(posedge clk);
            #1;
            n++;
        end
        i_req_valid = 1'b0;
        if (!accepted) begin
            timeouts++;
            $display("timeout at %0t: request was never accepted", $time);
        end else begin
            n = 0;
            while (!finished && n < WAIT_LIMIT) begin
                @(negedge clk);
                finished = o_done;
                @(posedge clk);
                #1;
                n++;
            end
            if (!finished) begin
                timeouts++;
                $display("timeout at %0t: access never signalled done", $time);
            end
        end
    endtask

    // bytes go on the line most significant first
    task automatic write_access(input access_size_t size, input logic [31:0] wdata);
        int nbytes;
        nbytes = (size == SIZE_BYTE) ? 1 : ((size == SIZE_HALF) ? 2 : 4);
        for (int i = nbytes - 1; i >= 0; i--) begin
            exp_bytes.push_back(wdata[8*i +: 8]);
        end
        run_access(size, 1'b1, wdata);
        writes++;
    endtask

    task automatic read_access(input access_size_t size);
        int          nbytes;
        logic [31:0] val;
        nbytes = (size == SIZE_BYTE) ? 1 : ((size == SIZE_HALF) ? 2 : 4);
        val    = '0;
        for (int i = 0; i < nbytes; i++) begin
            if (exp_bytes.size() == 0) begin
                errors++;
                $display("FAIL %0t: read asks for more bytes than were sent", $time);
            end else begin
                val = {val[23:0], exp_bytes.pop_front()};
            end
        end
        if (size == SIZE_BYTE) begin
            exp_rdata = {{24{val[7]}}, val[7:0]};
        end else if (size == SIZE_HALF) begin
            exp_rdata = {{16{val[15]}}, val[15:0]};
        end else begin
            exp_rdata = val;
        end
        read_active = 1'b1;
        run_access(size, 1'b0, 32'h0);
        read_active = 1'b0;
        reads++;
    endtask

    // line high for more than a frame means nothing is in flight
    task automatic wait_line_idle();
        int n;
        int quiet;
        n     = 0;
        quiet = 0;
        while (quiet < IDLE_CYCLES && n < WAIT_LIMIT) begin
            @(negedge clk);
            quiet = serial_line ? quiet + 1 : 0;
            n++;
        end
        @(posedge clk);
        #1;
        if (quiet < IDLE_CYCLES) begin
            timeouts++;
            $display("timeout at %0t: serial line never went idle", $time);
        end
    endtask

    initial begin
        i_rst       = 1'b1;
        i_req_valid = 1'b0;
        i_size      = SIZE_WORD;
        i_write     = 1'b0;
        i_wdata     = '0;
        exp_rdata   = '0;
        read_active = 1'b0;
        ovr_check   = 1'b0;
        ovr_expect  = 1'b0;
        done_base   = 0;
        repeat (10) @(posedge clk);
        #1;
        i_rst     = 1'b0;
        ovr_check = 1'b1;

        write_access(SIZE_WORD, random_word());
        read_access(SIZE_WORD);

        // bit 15 set so the read extends with ones
        write_access(SIZE_HALF, random_word() | 32'h0000_8000);
        read_access(SIZE_HALF);

        write_access(SIZE_WORD, random_word() | 32'h8000_0000);
        repeat (4) read_access(SIZE_BYTE);

        // 24 bytes outrun both the line and the receive queue
        ovr_check = 1'b0;
        done_base = done_cnt;
        repeat (6) write_access(SIZE_WORD, random_word());
        a_six_done: assert (done_cnt - done_base == 6)
            else begin
                errors++;
                $display("FAIL %0t: %0d of 6 writes completed", $time,
                         done_cnt - done_base);
            end

        wait_line_idle();
        // receive queue kept only the oldest bytes
        while (exp_bytes.size() > `UART_FIFO_DEPTH) begin
            void'(exp_bytes.pop_back());
        end
        ovr_expect = 1'b1;
        ovr_check  = 1'b1;
        repeat (4) read_access(SIZE_WORD);

        $display("summary: %0d writes, %0d reads, %0d errors, %0d timeouts",
                 writes, reads, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: uart_manage.f
+incdir+source
source/uart_pkg.sv
source/byte_fifo.sv
source/uart_rx.sv
source/uart_tx.sv
source/uart_access.sv
source/uart_manage.sv
verification/tb_uart_manage.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_uart_manage -f uart_manage.f
	./obj_dir/Vtb_uart_manage | tee sim.log
	@! grep -q "=== FAIL ===" sim.log
	@grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log
